/* dv/mem_system_tb.sv */
// Directed tests against a shadow memory and a tag model; one request in flight at a time
// Inputs change on the falling edge, outputs are sampled there too
`timescale 1ns/10ps

module mem_system_tb
   import mem_system_pkg::*;
();

   localparam int DONE_TIMEOUT = 200;
   localparam int HIT_LATENCY  = 2;

   logic     clk;
   logic     arst_n;
   ms_addr_t addr;
   ms_word_t data_in;
   logic     rd;
   logic     wr;
   ms_word_t data_out;
   logic     done;
   logic     stall;
   logic     cache_hit;
   logic     err;

   // Reference model
   ms_word_t    shadow [int];
   logic [63:0] model_valid;
   ms_tag_t     model_tag [64];

   int error_count;
   int check_count;

   mem_system mem_system_i (
      .clk, .arst_n, .addr, .data_in, .rd, .wr,
      .data_out, .done, .stall, .cache_hit, .err
   );

   initial clk = 1'b0;
   always #2 clk = ~clk;

   task automatic check_word(input string name, input ms_word_t exp, input ms_word_t act);
      check_count++;
      if (act !== exp) begin
         error_count++;
         $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      check_count++;
      if (act !== exp) begin
         error_count++;
         $display("MISMATCH at %0t: %s expected %b, got %b", $time, name, exp, act);
      end
   endtask

   task automatic check_latency(input string name, input int exp, input int act);
      check_count++;
      if (act != exp) begin
         error_count++;
         $display("MISMATCH at %0t: %s expected %0d, got %0d", $time, name, exp, act);
      end
   endtask

   // Cycles counted in falling edges from the drive edge
   task automatic wait_done(output int cycles);
      int   n;
      logic stall_dropped;
      n = 0;
      stall_dropped = 1'b0;
      do begin
         @(negedge clk);
         n++;
         // Stall covers every cycle from sampling up to done
         if (done !== 1'b1 && !stall_dropped) begin
            check_bit("stall", 1'b1, stall);
            stall_dropped = (stall !== 1'b1);
         end
      end while (done !== 1'b1 && n < DONE_TIMEOUT);
      cycles = n;
      if (done === 1'b1) begin
         check_bit("stall", 1'b0, stall);
      end else begin
         error_count++;
         $display("Timeout at %0t: done never came within %0d cycles", $time, DONE_TIMEOUT);
         $display("TB FAILED");
         $finish;
      end
   endtask

   // Drive one request, hold it until done, then drop the strobe
   task automatic send_request(input logic is_wr, input ms_addr_t a, input ms_word_t d,
                               output ms_word_t got_data, output logic got_hit,
                               output logic got_err, output int cycles);
      @(negedge clk);
      addr    = a;
      data_in = d;
      rd      = !is_wr;
      wr      = is_wr;
      wait_done(cycles);
      got_data = data_out;
      got_hit  = cache_hit;
      got_err  = err;
      rd = 1'b0;
      wr = 1'b0;
   endtask

   function automatic ms_addr_t make_addr(input ms_tag_t tag, input ms_index_t idx);
      return {tag, idx, 1'b0};
   endfunction

   // Never-written words read as zero
   function automatic ms_word_t model_read(input ms_addr_t a);
      if (shadow.exists(int'(a[15:1]))) begin
         return shadow[int'(a[15:1])];
      end
      return '0;
   endfunction

   function automatic logic model_hit(input ms_addr_t a);
      ms_index_t idx;
      idx = a[6:1];
      return model_valid[idx] && (model_tag[idx] == a[15:7]);
   endfunction

   // Even-address access checked against the model, then the model updated
   task automatic access_and_check(input logic is_wr, input ms_addr_t a, input ms_word_t d);
      logic     exp_hit;
      ms_word_t exp_data;
      ms_word_t got_data;
      logic     got_hit;
      logic     got_err;
      int       cycles;
      exp_hit  = model_hit(a);
      exp_data = is_wr ? d : model_read(a);
      send_request(is_wr, a, d, got_data, got_hit, got_err, cycles);
      check_bit("err", 1'b0, got_err);
      check_bit("cache_hit", exp_hit, got_hit);
      check_word("data_out", exp_data, got_data);
      if (exp_hit) begin
         check_latency("done latency", HIT_LATENCY, cycles);
      end
      model_valid[a[6:1]] = 1'b1;
      model_tag[a[6:1]]   = a[15:7];
      if (is_wr) begin
         shadow[int'(a[15:1])] = d;
      end
   endtask

   task automatic finish_test(input string name, input int errors_at_start);
      $display("%s: finished with %0d errors", name, error_count - errors_at_start);
   endtask

   task automatic reset_and_cold_read();
      int start;
      start = error_count;
      check_bit("done", 1'b0, done);
      check_bit("stall", 1'b0, stall);
      check_bit("cache_hit", 1'b0, cache_hit);
      check_bit("err", 1'b0, err);
      check_word("data_out", '0, data_out);
      // Cold miss, then a hit on the same word
      access_and_check(1'b0, make_addr(9'h011, 6'd5), '0);
      access_and_check(1'b0, make_addr(9'h011, 6'd5), '0);
      finish_test("reset and cold read", start);
   endtask

   task automatic write_miss_then_hit();
      int start;
      start = error_count;
      access_and_check(1'b1, make_addr(9'h0a2, 6'd12), 16'hbeef);
      access_and_check(1'b0, make_addr(9'h0a2, 6'd12), '0);
      finish_test("write miss then read hit", start);
   endtask

   task automatic dirty_eviction();
      int start;
      start = error_count;
      access_and_check(1'b1, make_addr(9'h033, 6'd20), 16'h1234);
      // Same index, other tag pushes the dirty line out
      access_and_check(1'b0, make_addr(9'h144, 6'd20), '0);
      access_and_check(1'b0, make_addr(9'h033, 6'd20), '0);
      finish_test("dirty eviction", start);
   endtask

   task automatic odd_address_refused();
      int       start;
      ms_word_t got_data;
      logic     got_hit;
      logic     got_err;
      int       cycles;
      start = error_count;
      access_and_check(1'b1, make_addr(9'h055, 6'd33), 16'hc0de);
      // Odd write to a conflicting tag must leave line and memory alone
      send_request(1'b1, make_addr(9'h066, 6'd33) | 16'h0001, 16'hdead,
                   got_data, got_hit, got_err, cycles);
      check_bit("err", 1'b1, got_err);
      check_bit("cache_hit", 1'b0, got_hit);
      check_latency("done latency", HIT_LATENCY, cycles);
      access_and_check(1'b0, make_addr(9'h055, 6'd33), '0);
      access_and_check(1'b0, make_addr(9'h066, 6'd33), '0);
      finish_test("odd address refused", start);
   endtask

   task automatic random_mix();
      int       start;
      logic     is_wr;
      ms_tag_t  tag;
      ms_index_t idx;
      ms_word_t d;
      start = error_count;
      for (int i = 0; i < 200; i++) begin
         // Few indices and tags so hits, misses and evictions all occur
         is_wr = 1'($urandom % 2);
         tag   = ms_tag_t'($urandom % 4);
         idx   = ms_index_t'(8 + ($urandom % 4));
         d     = ms_word_t'($urandom);
         access_and_check(is_wr, make_addr(tag, idx), d);
      end
      finish_test("random mix", start);
   endtask

   initial begin
      void'($urandom(98523));
      arst_n      = 1'b0;
      addr        = '0;
      data_in     = '0;
      rd          = 1'b0;
      wr          = 1'b0;
      error_count = 0;
      check_count = 0;
      model_valid = '0;
      for (int i = 0; i < 64; i++) begin
         model_tag[i] = '0;
      end
      repeat (2) @(negedge clk);
      arst_n = 1'b1;

      reset_and_cold_read();
      write_miss_then_hit();
      dirty_eviction();
      odd_address_refused();
      random_mix();

      $display("Checks run: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

/* project.f */
+incdir+source
source/mem_system_pkg.sv
source/cache_store.sv
source/banked_mem.sv
source/cache_ctrl.sv
source/mem_system.sv
dv/mem_system_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the cache memory system testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f \
   --top-module mem_system_tb -o mem_system_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/mem_system_sim 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if printf '%s\n' "$sim_out" | grep -q "^TB PASSED$"; then
   exit 0
fi
exit 1

/* source/banked_mem.sv */
// Four interleaved banks, bank from address bits 2..1, fixed busy time per access
// Writes land at issue; reads return after the latency, one read in flight assumed
`timescale 1ns/10ps
`include "mem_system_params.svh"

module banked_mem
   import mem_system_pkg::*;
(
   input  logic     clk,
   input  logic     arst_n,
   input  ms_addr_t mem_addr,
   input  ms_word_t mem_wdata,
   input  logic     mem_rd,
   input  logic     mem_wr,
   output ms_word_t mem_rdata,
   output ms_busy_t mem_busy,
   output logic     mem_rvalid
);

   localparam int NUM_BANKS  = 4;
   localparam int BANK_WORDS = `MS_MEM_WORDS / NUM_BANKS;
   localparam int ROW_BITS   = $clog2(BANK_WORDS);
   localparam int CNT_BITS   = $clog2(`MS_MEM_LATENCY + 1);

   ms_bank_t            bank;
   logic [ROW_BITS-1:0] row;
   // Word storage, zero at power up
   ms_word_t            bank_mem [NUM_BANKS][BANK_WORDS] = '{default: '0};
   logic [CNT_BITS-1:0] busy_cnt [NUM_BANKS];
   logic [NUM_BANKS-1:0] rd_pend;
   logic [NUM_BANKS-1:0] rd_done;
   // Word captured at read issue
   ms_word_t            rd_word [NUM_BANKS];

   assign bank = mem_addr[2:1];
   assign row  = mem_addr[ROW_BITS+2:3];

   // Busy flags and read completion per bank
   always_comb begin
      for (int b = 0; b < NUM_BANKS; b++) begin
         mem_busy[b] = (busy_cnt[b] != '0);
         rd_done[b]  = rd_pend[b] && (busy_cnt[b] == CNT_BITS'(1));
      end
   end

   // Array access and read return data
   always_ff @(posedge clk) begin
      if (mem_wr) begin
         bank_mem[bank][row] <= mem_wdata;
      end
      if (mem_rd) begin
         rd_word[bank] <= bank_mem[bank][row];
      end
      for (int b = 0; b < NUM_BANKS; b++) begin
         if (rd_done[b]) begin
            mem_rdata <= rd_word[b];
         end
      end
   end

   // Busy counters and pending reads
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int b = 0; b < NUM_BANKS; b++) begin
            busy_cnt[b] <= '0;
         end
         rd_pend    <= '0;
         mem_rvalid <= 1'b0;
      end else begin
         mem_rvalid <= |rd_done;
         for (int b = 0; b < NUM_BANKS; b++) begin
            if ((mem_rd || mem_wr) && (bank == ms_bank_t'(b))) begin
               busy_cnt[b] <= CNT_BITS'(`MS_MEM_LATENCY);
               rd_pend[b]  <= mem_rd;
            end else if (busy_cnt[b] != '0) begin
               busy_cnt[b] <= busy_cnt[b] - 1'b1;
               if (rd_done[b]) begin
                  rd_pend[b] <= 1'b0;
               end
            end
         end
      end
   end

   // Controller must hold off while the target bank is busy
   no_access_to_busy_bank: assert property (
      @(posedge clk) disable iff (!arst_n)
      (mem_rd || mem_wr) |-> !mem_busy[bank]
   );

endmodule

/* source/cache_ctrl.sv */
// Write-back, write-allocate controller; requester holds addr, data and strobe until done
// Odd addresses end with err and change nothing; all top outputs are flopped
`timescale 1ns/10ps
`include "mem_system_params.svh"

module cache_ctrl
   import mem_system_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n,
   input  ms_addr_t  addr,
   input  ms_word_t  data_in,
   input  logic      rd,
   input  logic      wr,
   input  logic      hit,
   input  logic      line_dirty,
   input  ms_tag_t   line_tag,
   input  ms_word_t  line_data,
   input  ms_busy_t  mem_busy,
   input  ms_word_t  mem_rdata,
   input  logic      mem_rvalid,
   output ms_word_t  data_out,
   output logic      done,
   output logic      stall,
   output logic      cache_hit,
   output logic      err,
   output ms_index_t lookup_index,
   output ms_tag_t   lookup_tag,
   output logic      write_en,
   output ms_word_t  write_data,
   output logic      write_dirty,
   output ms_addr_t  mem_addr,
   output ms_word_t  mem_wdata,
   output logic      mem_rd,
   output logic      mem_wr
);

   ms_state_t state, state_nxt;
   // Captured request
   ms_addr_t  req_addr;
   ms_word_t  req_data;
   logic      req_wr;
   ms_word_t  fill_data;
   ms_bank_t  req_bank;
   logic      accept;
   logic      done_nxt, hit_nxt, err_nxt;
   ms_word_t  data_out_nxt;

   assign lookup_index = req_addr[`MS_INDEX_BITS:1];
   assign lookup_tag   = req_addr[`MS_ADDR_BITS-1:`MS_INDEX_BITS+1];
   // Victim shares the index, hence the bank
   assign req_bank     = req_addr[2:1];
   // Strobe is still up while done shows, so skip that cycle
   assign accept       = (rd || wr) && !done;

   // Request and fill registers
   always_ff @(posedge clk) begin
      if (state == ST_IDLE && accept) begin
         req_addr <= addr;
         req_data <= data_in;
         req_wr   <= wr;
      end
      if (state == ST_RD_WAIT && mem_rvalid) begin
         fill_data <= mem_rdata;
      end
   end

   // Next state, cache and memory strobes
   always_comb begin
      state_nxt    = state;
      done_nxt     = 1'b0;
      hit_nxt      = 1'b0;
      err_nxt      = 1'b0;
      data_out_nxt = data_out;
      write_en     = 1'b0;
      write_data   = req_data;
      write_dirty  = 1'b1;
      mem_addr     = {req_addr[`MS_ADDR_BITS-1:1], 1'b0};
      mem_wdata    = line_data;
      mem_rd       = 1'b0;
      mem_wr       = 1'b0;
      case (state)
         ST_IDLE: begin
            if (accept) begin
               state_nxt = ST_COMPARE;
            end
         end
         ST_COMPARE: begin
            if (req_addr[0]) begin
               // Refused, nothing touched
               done_nxt  = 1'b1;
               err_nxt   = 1'b1;
               state_nxt = ST_IDLE;
            end else if (hit || (req_wr && !line_dirty)) begin
               // Hit, or store into a clean line
               done_nxt     = 1'b1;
               hit_nxt      = hit;
               write_en     = req_wr;
               data_out_nxt = req_wr ? req_data : line_data;
               state_nxt    = ST_IDLE;
            end else if (line_dirty) begin
               state_nxt = ST_WB_ISSUE;
            end else begin
               state_nxt = ST_RD_ISSUE;
            end
         end
         ST_WB_ISSUE: begin
            // Victim address from stored tag
            mem_addr = {line_tag, lookup_index, 1'b0};
            if (!mem_busy[req_bank]) begin
               mem_wr    = 1'b1;
               state_nxt = ST_WB_WAIT;
            end
         end
         ST_WB_WAIT: begin
            if (req_wr) begin
               // Write-allocate without a memory read
               write_en     = 1'b1;
               data_out_nxt = req_data;
               done_nxt     = 1'b1;
               state_nxt    = ST_IDLE;
            end else begin
               state_nxt = ST_RD_ISSUE;
            end
         end
         ST_RD_ISSUE: begin
            if (!mem_busy[req_bank]) begin
               mem_rd    = 1'b1;
               state_nxt = ST_RD_WAIT;
            end
         end
         ST_RD_WAIT: begin
            if (mem_rvalid) begin
               state_nxt = ST_FILL;
            end
         end
         ST_FILL: begin
            // Fill lands clean
            write_en     = 1'b1;
            write_data   = fill_data;
            write_dirty  = 1'b0;
            data_out_nxt = fill_data;
            done_nxt     = 1'b1;
            state_nxt    = ST_IDLE;
         end
         default: state_nxt = ST_IDLE;
      endcase
   end

   // Output flops
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state     <= ST_IDLE;
         done      <= 1'b0;
         stall     <= 1'b0;
         cache_hit <= 1'b0;
         err       <= 1'b0;
         data_out  <= '0;
      end else begin
         state     <= state_nxt;
         done      <= done_nxt;
         // Busy whenever the request is still open next cycle
         stall     <= (state_nxt != ST_IDLE);
         cache_hit <= hit_nxt;
         err       <= err_nxt;
         data_out  <= data_out_nxt;
      end
   end

   stall_done_exclusive: assert property (
      @(posedge clk) disable iff (!arst_n) !(stall && done));
   mem_rd_wr_exclusive: assert property (
      @(posedge clk) disable iff (!arst_n) !(mem_rd && mem_wr));

endmodule

/* source/cache_store.sv */
// Direct-mapped store of one-word lines; lookup is combinational
// Tag and data arrays power up unknown, only valid and dirty are reset
`timescale 1ns/10ps
`include "mem_system_params.svh"

module cache_store
   import mem_system_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n,
   input  ms_index_t lookup_index,
   input  ms_tag_t   lookup_tag,
   input  logic      write_en,
   input  ms_word_t  write_data,
   input  logic      write_dirty,
   output logic      hit,
   output logic      line_dirty,
   output ms_tag_t   line_tag,
   output ms_word_t  line_data
);

   localparam int NUM_LINES = 1 << `MS_INDEX_BITS;

   // Per-line flags
   logic [NUM_LINES-1:0] valid_q;
   logic [NUM_LINES-1:0] dirty_q;

   // Tag and data arrays
   ms_tag_t  tag_mem  [NUM_LINES];
   ms_word_t data_mem [NUM_LINES];

   // Lookup of the addressed line
   // Dirty is qualified by valid, so a dirty line always holds a victim
   assign hit        = valid_q[lookup_index] && (tag_mem[lookup_index] == lookup_tag);
   assign line_dirty = valid_q[lookup_index] && dirty_q[lookup_index];
   assign line_tag   = tag_mem[lookup_index];
   assign line_data  = data_mem[lookup_index];

   // Flag update
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else if (write_en) begin
         valid_q[lookup_index] <= 1'b1;
         // Fill writes clean, a store writes dirty
         dirty_q[lookup_index] <= write_dirty;
      end
   end

   // Tag and data update
   always_ff @(posedge clk) begin
      if (write_en) begin
         // Line takes the tag of the current request
         tag_mem[lookup_index]  <= lookup_tag;
         data_mem[lookup_index] <= write_data;
      end
   end

   // Fill and store data must be resolved before they reach the line
   write_data_known: assert property (
      @(posedge clk) disable iff (!arst_n)
      write_en |-> !$isunknown(write_data)
   );

endmodule

/* source/mem_system.sv */
// Cache in front of the banked memory; one request at a time
// Hits and refused odd addresses finish 2 cycles after sampling
`timescale 1ns/10ps

module mem_system
   import mem_system_pkg::*;
(
   input  logic     clk,
   input  logic     arst_n,
   input  ms_addr_t addr,
   input  ms_word_t data_in,
   input  logic     rd,
   input  logic     wr,
   output ms_word_t data_out,
   output logic     done,
   output logic     stall,
   output logic     cache_hit,
   output logic     err
);

   // Controller to cache
   ms_index_t lookup_index;
   ms_tag_t   lookup_tag, line_tag;
   logic      write_en, write_dirty, hit, line_dirty;
   ms_word_t  write_data, line_data;

   // Controller to memory
   ms_addr_t  mem_addr;
   ms_word_t  mem_wdata, mem_rdata;
   logic      mem_rd, mem_wr, mem_rvalid;
   ms_busy_t  mem_busy;

   cache_ctrl cache_ctrl_i (
      .clk, .arst_n, .addr, .data_in, .rd, .wr,
      .hit, .line_dirty, .line_tag, .line_data,
      .mem_busy, .mem_rdata, .mem_rvalid,
      .data_out, .done, .stall, .cache_hit, .err,
      .lookup_index, .lookup_tag, .write_en, .write_data, .write_dirty,
      .mem_addr, .mem_wdata, .mem_rd, .mem_wr
   );

   cache_store cache_store_i (
      .clk, .arst_n, .lookup_index, .lookup_tag, .write_en, .write_data,
      .write_dirty, .hit, .line_dirty, .line_tag, .line_data
   );

   banked_mem banked_mem_i (
      .clk, .arst_n, .mem_addr, .mem_wdata, .mem_rd, .mem_wr,
      .mem_rdata, .mem_busy, .mem_rvalid
   );

endmodule

/* source/mem_system_params.svh */
// Widths, cache geometry and memory timing for the memory system
// Byte addresses; bit 0 selects a byte and must be zero for any access

`ifndef MEM_SYSTEM_PARAMS_SVH
`define MEM_SYSTEM_PARAMS_SVH

// Data and address widths
`define MS_WORD_BITS 16
`define MS_ADDR_BITS 16

// 64 one-word lines, index from address bits 6..1
`define MS_INDEX_BITS 6
`define MS_TAG_BITS (`MS_ADDR_BITS - `MS_INDEX_BITS - 1)

// Cycles a bank stays busy per access
`define MS_MEM_LATENCY 4
`define MS_MEM_WORDS 32768

`endif

/* source/mem_system_pkg.sv */
// Shared types for the cache and the banked memory
// Tag is the address above the index bits; bit 0 is the byte select

`include "mem_system_params.svh"

package mem_system_pkg;

   typedef logic [`MS_WORD_BITS-1:0]  ms_word_t;
   typedef logic [`MS_ADDR_BITS-1:0]  ms_addr_t;
   typedef logic [`MS_TAG_BITS-1:0]   ms_tag_t;
   typedef logic [`MS_INDEX_BITS-1:0] ms_index_t;
   // Bank number is address bits 2..1
   typedef logic [1:0]                ms_bank_t;
   // One busy flag per bank
   typedef logic [3:0]                ms_busy_t;

   // Controller states
   typedef enum logic [2:0] {
      ST_IDLE, ST_COMPARE, ST_WB_ISSUE, ST_WB_WAIT, ST_RD_ISSUE, ST_RD_WAIT, ST_FILL
   } ms_state_t;

endpackage
